/* verilog/icache_pkg.sv */
package icache_pkg;

  // Untranslated low bits of a virtual address
  localparam int page_offset_width_gp = 12;

  localparam int instr_width_gp = 32;

  // Instructions per cache block
  localparam int block_words_gp = 4;

  localparam int paddr_width_gp = 32;

  // Physical tag covers everything above the page offset
  localparam int ptag_width_gp = paddr_width_gp - page_offset_width_gp;

  typedef logic [instr_width_gp-1:0] instr_t;

  // Physical byte address
  typedef logic [paddr_width_gp-1:0] paddr_t;

  // Word 0 sits at the lowest address of the block
  typedef instr_t [block_words_gp-1:0] block_t;

endpackage

/* verilog/fetch_replay_fifo.sv */
module fetch_replay_fifo #(
  parameter int vaddr_width_p = 32,
  parameter int fifo_els_p    = 8
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic                                  enq_v_i,
  output logic                                  enq_ready_o,
  input  logic [vaddr_width_p-1:0]              enq_vaddr_i,
  input  logic [icache_pkg::ptag_width_gp-1:0]  enq_ptag_i,
  input  logic                                  enq_uncached_i,

  output logic                                  head_v_o,
  output logic [vaddr_width_p-1:0]              head_vaddr_o,
  output logic [icache_pkg::ptag_width_gp-1:0]  head_ptag_o,
  output logic                                  head_uncached_o,

  input  logic                                  issue_i,
  input  logic                                  deq_i,
  input  logic                                  roll_i
);
  import icache_pkg::*;

  localparam int ptr_width_lp = $clog2(fifo_els_p);

  logic [vaddr_width_p-1:0] vaddr_mem [fifo_els_p];
  logic [ptag_width_gp-1:0] ptag_mem [fifo_els_p];
  logic [fifo_els_p-1:0]    uncached_mem;

  // Extra top bit tells a full FIFO from an empty one
  logic [ptr_width_lp:0] wptr_r;
  logic [ptr_width_lp:0] iptr_r;
  logic [ptr_width_lp:0] cptr_r;

  logic full;
  logic enq;

  // Space is only freed once an entry has returned its instruction
  assign full = (wptr_r[ptr_width_lp] != cptr_r[ptr_width_lp])
             && (wptr_r[ptr_width_lp-1:0] == cptr_r[ptr_width_lp-1:0]);

  assign enq_ready_o = ~full;
  assign enq         = enq_v_i & ~full;

  // Head is the oldest entry not yet sent to the cache
  assign head_v_o        = (iptr_r != wptr_r);
  assign head_vaddr_o    = vaddr_mem[iptr_r[ptr_width_lp-1:0]];
  assign head_ptag_o     = ptag_mem[iptr_r[ptr_width_lp-1:0]];
  assign head_uncached_o = uncached_mem[iptr_r[ptr_width_lp-1:0]];

  always_ff @(posedge clk_i) begin
    if (enq) begin
      vaddr_mem[wptr_r[ptr_width_lp-1:0]]    <= enq_vaddr_i;
      ptag_mem[wptr_r[ptr_width_lp-1:0]]     <= enq_ptag_i;
      uncached_mem[wptr_r[ptr_width_lp-1:0]] <= enq_uncached_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_r <= '0;
      iptr_r <= '0;
      cptr_r <= '0;
    end else begin
      if (enq) begin
        wptr_r <= wptr_r + 1'b1;
      end
      // Replay restarts from the oldest uncommitted entry
      if (roll_i) begin
        iptr_r <= cptr_r;
      end else if (issue_i) begin
        iptr_r <= iptr_r + 1'b1;
      end
      if (deq_i) begin
        cptr_r <= cptr_r + 1'b1;
      end
    end
  end

endmodule

/* verilog/icache.sv */
module icache #(
  parameter int vaddr_width_p = 32,
  parameter int sets_p        = 16
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic [vaddr_width_p-1:0]              vaddr_i,
  input  logic [icache_pkg::ptag_width_gp-1:0]  ptag_i,
  input  logic                                  uncached_i,
  input  logic                                  issue_i,
  output logic                                  ready_o,

  output icache_pkg::instr_t                    data_o,
  output logic                                  data_v_o,

  output logic                                  miss_v_o,
  output icache_pkg::paddr_t                    miss_addr_o,
  output logic                                  miss_uncached_o,
  input  logic                                  miss_ready_i,

  input  logic                                  fill_v_i,
  input  logic [$clog2(sets_p)-1:0]             fill_index_i,
  input  logic [icache_pkg::ptag_width_gp-1:0]  fill_tag_i,
  input  icache_pkg::block_t                    fill_block_i,
  input  logic                                  unc_v_i,
  input  icache_pkg::instr_t                    unc_instr_i
);
  import icache_pkg::*;

  localparam int index_width_lp  = $clog2(sets_p);
  localparam int byte_offset_lp  = $clog2(instr_width_gp / 8);
  localparam int word_offset_lp  = $clog2(block_words_gp);
  localparam int block_offset_lp = byte_offset_lp + word_offset_lp;

  logic [ptag_width_gp-1:0] tag_mem [sets_p];
  block_t                   data_mem [sets_p];
  logic [sets_p-1:0]        valid_r;

  logic [index_width_lp-1:0] index_li;

  // Stage one results, compared in the following cycle
  logic                            tl_v_r;
  logic [ptag_width_gp-1:0]        tl_tag_r;
  logic                            tl_valid_r;
  block_t                          tl_block_r;
  logic [page_offset_width_gp-1:0] tl_offset_r;

  logic   unc_v_r;
  instr_t unc_instr_r;
  logic   pending_r;

  logic                      hit_cached;
  logic                      hit_unc;
  logic                      hit;
  logic                      miss;
  logic [word_offset_lp-1:0] word_sel;

  // Index comes from the page offset, so no translation is needed here
  assign index_li = vaddr_i[block_offset_lp +: index_width_lp];

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_mem[fill_index_i]  <= fill_tag_i;
      data_mem[fill_index_i] <= fill_block_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r[fill_index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    tl_tag_r    <= tag_mem[index_li];
    tl_valid_r  <= valid_r[index_li];
    tl_block_r  <= data_mem[index_li];
    tl_offset_r <= vaddr_i[page_offset_width_gp-1:0];
  end

  // A miss kills the younger request entering stage two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tl_v_r <= 1'b0;
    end else begin
      tl_v_r <= issue_i & ~miss;
    end
  end

  // Stage two, ptag_i and uncached_i belong to the request held here
  assign word_sel   = tl_offset_r[byte_offset_lp +: word_offset_lp];
  assign hit_unc    = uncached_i & unc_v_r;
  assign hit_cached = ~uncached_i & tl_valid_r & (tl_tag_r == ptag_i);
  assign hit        = tl_v_r & (hit_unc | hit_cached);
  assign miss       = tl_v_r & ~(hit_unc | hit_cached);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_v_o <= 1'b0;
    end else begin
      data_v_o <= hit;
    end
  end

  always_ff @(posedge clk_i) begin
    data_o <= hit_unc ? unc_instr_r : tl_block_r[word_sel];
  end

  // One-shot holding register for uncached words
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      unc_v_r <= 1'b0;
    end else if (unc_v_i) begin
      unc_v_r <= 1'b1;
    end else if (tl_v_r & hit_unc) begin
      unc_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (unc_v_i) begin
      unc_instr_r <= unc_instr_i;
    end
  end

  // Stall new issues until the fill lands
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_r <= 1'b0;
    end else if (miss) begin
      pending_r <= 1'b1;
    end else if (fill_v_i | unc_v_i) begin
      pending_r <= 1'b0;
    end
  end

  assign ready_o = ~pending_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      miss_v_o <= 1'b0;
    end else if (miss) begin
      miss_v_o <= 1'b1;
    end else if (miss_ready_i) begin
      miss_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss) begin
      miss_addr_o     <= {ptag_i, tl_offset_r};
      miss_uncached_o <= uncached_i;
    end
  end

endmodule

/* verilog/icache_fill_engine.sv */
module icache_fill_engine #(
  parameter int sets_p = 16
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic                                  miss_v_i,
  input  icache_pkg::paddr_t                    miss_addr_i,
  input  logic                                  miss_uncached_i,
  output logic                                  miss_ready_o,

  output icache_pkg::paddr_t                    mem_cmd_addr_o,
  output logic                                  mem_cmd_uncached_o,
  output logic                                  mem_cmd_v_o,
  input  logic                                  mem_cmd_ready_i,

  input  logic                                  resp_v_i,
  input  icache_pkg::block_t                    resp_data_i,
  output logic                                  resp_yumi_o,

  output logic                                  fill_v_o,
  output logic [$clog2(sets_p)-1:0]             fill_index_o,
  output logic [icache_pkg::ptag_width_gp-1:0]  fill_tag_o,
  output icache_pkg::block_t                    fill_block_o,
  output logic                                  unc_v_o,
  output icache_pkg::instr_t                    unc_instr_o
);
  import icache_pkg::*;

  localparam int index_width_lp  = $clog2(sets_p);
  localparam int block_offset_lp = $clog2(block_words_gp * instr_width_gp / 8);

  localparam logic [1:0] idle_s = 2'd0;
  localparam logic [1:0] send_s = 2'd1;
  localparam logic [1:0] wait_s = 2'd2;

  logic [1:0] state_r;
  paddr_t     addr_r;
  logic       uncached_r;
  paddr_t     aligned_addr;

  always_comb begin
    aligned_addr = miss_addr_i;
    aligned_addr[block_offset_lp-1:0] = '0;
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == idle_s) && miss_v_i) begin
      // Uncached reads fetch exactly the requested word
      addr_r     <= miss_uncached_i ? miss_addr_i : aligned_addr;
      uncached_r <= miss_uncached_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r <= idle_s;
    end else begin
      case (state_r)
        idle_s:  if (miss_v_i) state_r <= send_s;
        send_s:  if (mem_cmd_ready_i) state_r <= wait_s;
        wait_s:  if (resp_v_i) state_r <= idle_s;
        default: state_r <= idle_s;
      endcase
    end
  end

  assign miss_ready_o       = (state_r == idle_s);
  assign mem_cmd_v_o        = (state_r == send_s);
  assign mem_cmd_addr_o     = addr_r;
  assign mem_cmd_uncached_o = uncached_r;

  assign resp_yumi_o = (state_r == wait_s) & resp_v_i;

  // Uncached responses never allocate a line
  assign fill_v_o     = resp_yumi_o & ~uncached_r;
  assign fill_index_o = addr_r[block_offset_lp +: index_width_lp];
  assign fill_tag_o   = addr_r[paddr_width_gp-1 -: ptag_width_gp];
  assign fill_block_o = resp_data_i;

  // Requested word comes back in word 0
  assign unc_v_o     = resp_yumi_o & uncached_r;
  assign unc_instr_o = resp_data_i[0];

endmodule

/* verilog/mem_resp_buffer.sv */
module mem_resp_buffer (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  logic               v_i,
  input  icache_pkg::block_t data_i,
  output logic               yumi_o,

  output logic               v_o,
  output icache_pkg::block_t data_o,
  input  logic               yumi_i
);
  import icache_pkg::*;

  logic   full_r;
  block_t data_r;

  // Take a new response only into an empty slot
  assign yumi_o = v_i & ~full_r;
  assign v_o    = full_r;
  assign data_o = data_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_r <= 1'b0;
    end else if (yumi_o) begin
      full_r <= 1'b1;
    end else if (yumi_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (yumi_o) begin
      data_r <= data_i;
    end
  end

endmodule

/* verilog/icache_subsystem.sv */
module icache_subsystem #(
  parameter int vaddr_width_p = 32,
  parameter int sets_p        = 16,
  parameter int fifo_els_p    = 8
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  input  logic [vaddr_width_p-1:0]              vaddr_i,
  input  logic [icache_pkg::ptag_width_gp-1:0]  ptag_i,
  input  logic                                  uncached_i,
  input  logic                                  vaddr_v_i,
  output logic                                  vaddr_ready_o,

  output icache_pkg::instr_t                    data_o,
  output logic                                  data_v_o,

  output icache_pkg::paddr_t                    mem_cmd_addr_o,
  output logic                                  mem_cmd_uncached_o,
  output logic                                  mem_cmd_v_o,
  input  logic                                  mem_cmd_ready_i,

  input  icache_pkg::block_t                    mem_resp_data_i,
  input  logic                                  mem_resp_v_i,
  output logic                                  mem_resp_yumi_o
);
  import icache_pkg::*;

  logic                     head_v_lo;
  logic [vaddr_width_p-1:0] head_vaddr_lo;
  logic [ptag_width_gp-1:0] head_ptag_lo;
  logic                     head_uncached_lo;

  logic cache_ready_lo;
  logic issue_li;
  logic issue_r;
  logic issue_rr;
  logic rollback_li;

  // Tag and uncached flag reach the cache one cycle after the index
  logic [ptag_width_gp-1:0] ptag_r;
  logic                     uncached_r;

  logic   miss_v_lo;
  paddr_t miss_addr_lo;
  logic   miss_uncached_lo;
  logic   miss_ready_lo;

  logic                      fill_v_lo;
  logic [$clog2(sets_p)-1:0] fill_index_lo;
  logic [ptag_width_gp-1:0]  fill_tag_lo;
  block_t                    fill_block_lo;
  logic                      unc_v_lo;
  instr_t                    unc_instr_lo;

  logic   resp_v_lo;
  block_t resp_data_lo;
  logic   resp_yumi_li;

  assign issue_li = head_v_lo & cache_ready_lo;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      issue_r  <= 1'b0;
      issue_rr <= 1'b0;
    end else begin
      issue_r  <= issue_li;
      issue_rr <= issue_r;
    end
  end

  // Issued two cycles ago but no instruction came back
  assign rollback_li = issue_rr & ~data_v_o;

  always_ff @(posedge clk_i) begin
    ptag_r     <= head_ptag_lo;
    uncached_r <= head_uncached_lo;
  end

  fetch_replay_fifo #(
    .vaddr_width_p(vaddr_width_p),
    .fifo_els_p   (fifo_els_p)
  ) u_fifo (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .enq_v_i        (vaddr_v_i),
    .enq_ready_o    (vaddr_ready_o),
    .enq_vaddr_i    (vaddr_i),
    .enq_ptag_i     (ptag_i),
    .enq_uncached_i (uncached_i),
    .head_v_o       (head_v_lo),
    .head_vaddr_o   (head_vaddr_lo),
    .head_ptag_o    (head_ptag_lo),
    .head_uncached_o(head_uncached_lo),
    .issue_i        (issue_li),
    .deq_i          (data_v_o),
    .roll_i         (rollback_li)
  );

  icache #(
    .vaddr_width_p(vaddr_width_p),
    .sets_p       (sets_p)
  ) u_icache (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .vaddr_i        (head_vaddr_lo),
    .ptag_i         (ptag_r),
    .uncached_i     (uncached_r),
    .issue_i        (issue_li),
    .ready_o        (cache_ready_lo),
    .data_o         (data_o),
    .data_v_o       (data_v_o),
    .miss_v_o       (miss_v_lo),
    .miss_addr_o    (miss_addr_lo),
    .miss_uncached_o(miss_uncached_lo),
    .miss_ready_i   (miss_ready_lo),
    .fill_v_i       (fill_v_lo),
    .fill_index_i   (fill_index_lo),
    .fill_tag_i     (fill_tag_lo),
    .fill_block_i   (fill_block_lo),
    .unc_v_i        (unc_v_lo),
    .unc_instr_i    (unc_instr_lo)
  );

  icache_fill_engine #(
    .sets_p(sets_p)
  ) u_fill_engine (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .miss_v_i          (miss_v_lo),
    .miss_addr_i       (miss_addr_lo),
    .miss_uncached_i   (miss_uncached_lo),
    .miss_ready_o      (miss_ready_lo),
    .mem_cmd_addr_o    (mem_cmd_addr_o),
    .mem_cmd_uncached_o(mem_cmd_uncached_o),
    .mem_cmd_v_o       (mem_cmd_v_o),
    .mem_cmd_ready_i   (mem_cmd_ready_i),
    .resp_v_i          (resp_v_lo),
    .resp_data_i       (resp_data_lo),
    .resp_yumi_o       (resp_yumi_li),
    .fill_v_o          (fill_v_lo),
    .fill_index_o      (fill_index_lo),
    .fill_tag_o        (fill_tag_lo),
    .fill_block_o      (fill_block_lo),
    .unc_v_o           (unc_v_lo),
    .unc_instr_o       (unc_instr_lo)
  );

  mem_resp_buffer u_resp_buffer (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .v_i    (mem_resp_v_i),
    .data_i (mem_resp_data_i),
    .yumi_o (mem_resp_yumi_o),
    .v_o    (resp_v_lo),
    .data_o (resp_data_lo),
    .yumi_i (resp_yumi_li)
  );

endmodule

/* testbench/tb_mem_model.sv */
module tb_mem_model #(
  parameter int latency_p = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,

  input  icache_pkg::paddr_t cmd_addr_i,
  input  logic               cmd_uncached_i,
  input  logic               cmd_v_i,
  output logic               cmd_ready_o,

  output icache_pkg::block_t resp_data_o,
  output logic               resp_v_o,
  input  logic               resp_yumi_i,

  input  logic               stall_i,
  output int                 cmd_count_o,
  output icache_pkg::paddr_t last_addr_o,
  output logic               last_uncached_o
);
  import icache_pkg::*;

  localparam int word_bytes_lp  = instr_width_gp / 8;
  localparam int block_bytes_lp = block_words_gp * word_bytes_lp;

  block_t blk;
  paddr_t base;
  logic   cmd_fire;
  logic   resp_fire;
  logic   pending;
  int     wait_cnt;

  // Handshakes are sampled at the falling edge, updates land just after the rising edge
  initial begin
    cmd_ready_o     = 1'b0;
    resp_v_o        = 1'b0;
    resp_data_o     = '0;
    cmd_count_o     = 0;
    last_addr_o     = '0;
    last_uncached_o = 1'b0;
    pending         = 1'b0;
    wait_cnt        = 0;
    forever begin
      @(negedge clk_i);
      cmd_fire  = cmd_v_i & cmd_ready_o;
      resp_fire = resp_v_o & resp_yumi_i;
      @(posedge clk_i);
      #1;
      if (!rst_n_i) begin
        cmd_ready_o = 1'b0;
        resp_v_o    = 1'b0;
        pending     = 1'b0;
      end else begin
        if (resp_fire) begin
          resp_v_o = 1'b0;
        end
        if (cmd_fire) begin
          cmd_count_o     = cmd_count_o + 1;
          last_addr_o     = cmd_addr_i;
          last_uncached_o = cmd_uncached_i;
          // Uncached reads return the exact word in slot 0
          base = cmd_uncached_i ? cmd_addr_i : (cmd_addr_i & ~paddr_t'(block_bytes_lp - 1));
          for (int i = 0; i < block_words_gp; i++) begin
            blk[i] = ~(base + paddr_t'(i * word_bytes_lp));
          end
          pending  = 1'b1;
          wait_cnt = latency_p;
        end else if (pending) begin
          if (wait_cnt == 0) begin
            resp_v_o    = 1'b1;
            resp_data_o = blk;
            pending     = 1'b0;
          end else begin
            wait_cnt = wait_cnt - 1;
          end
        end
        cmd_ready_o = ~stall_i;
      end
    end
  end

endmodule

/* testbench/tb_icache_subsystem.sv */
module tb_icache_subsystem;
  import icache_pkg::*;

  localparam int num_lines_lp    = 34;
  localparam int fields_lp       = 5;
  localparam int reset_cycles_lp = 8;
  localparam int timeout_lp      = 200 * num_lines_lp + reset_cycles_lp;
  localparam int block_bytes_lp  = block_words_gp * instr_width_gp / 8;

  logic                     clk;
  logic                     rst_n;
  logic [31:0]              vaddr;
  logic [ptag_width_gp-1:0] ptag;
  logic                     uncached;
  logic                     vaddr_v;
  logic                     vaddr_ready;
  instr_t                   data;
  logic                     data_v;
  paddr_t                   mem_cmd_addr;
  logic                     mem_cmd_uncached;
  logic                     mem_cmd_v;
  logic                     mem_cmd_ready;
  block_t                   mem_resp_data;
  logic                     mem_resp_v;
  logic                     mem_resp_yumi;

  logic   mem_stall;
  logic   hold_off;
  int     cmd_count;
  paddr_t last_cmd_addr;
  logic   last_cmd_uncached;
  logic   saw_full;
  int     out_idx;
  int     prev_count;
  int     cycles;

  // Five hex words per fetch line
  logic [31:0] pat_mem [0:fields_lp*num_lines_lp-1];

  icache_subsystem #(
    .vaddr_width_p(32),
    .sets_p       (16),
    .fifo_els_p   (8)
  ) DUT (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .vaddr_i           (vaddr),
    .ptag_i            (ptag),
    .uncached_i        (uncached),
    .vaddr_v_i         (vaddr_v),
    .vaddr_ready_o     (vaddr_ready),
    .data_o            (data),
    .data_v_o          (data_v),
    .mem_cmd_addr_o    (mem_cmd_addr),
    .mem_cmd_uncached_o(mem_cmd_uncached),
    .mem_cmd_v_o       (mem_cmd_v),
    .mem_cmd_ready_i   (mem_cmd_ready),
    .mem_resp_data_i   (mem_resp_data),
    .mem_resp_v_i      (mem_resp_v),
    .mem_resp_yumi_o   (mem_resp_yumi)
  );

  tb_mem_model u_mem (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .cmd_addr_i     (mem_cmd_addr),
    .cmd_uncached_i (mem_cmd_uncached),
    .cmd_v_i        (mem_cmd_v),
    .cmd_ready_o    (mem_cmd_ready),
    .resp_data_o    (mem_resp_data),
    .resp_v_o       (mem_resp_v),
    .resp_yumi_i    (mem_resp_yumi),
    .stall_i        (mem_stall),
    .cmd_count_o    (cmd_count),
    .last_addr_o    (last_cmd_addr),
    .last_uncached_o(last_cmd_uncached)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Memory stalls and enqueue gaps share one seeded stream
  initial begin
    void'($urandom(99055));
    mem_stall = 1'b0;
    hold_off  = 1'b0;
    forever begin
      @(negedge clk);
      mem_stall = ($urandom_range(3, 0) == 0);
      hold_off  = ($urandom_range(7, 0) == 0);
    end
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR: time %0t signal %s expected %b got %b",
                         $time, name, exp, act));
    end
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR: time %0t signal %s expected %h got %h",
                         $time, name, exp, act));
    end
  endtask

  task automatic check_cmd_count(input int exp_count, input int act_count,
                                 input paddr_t exp_addr, input paddr_t act_addr,
                                 input bit with_addr);
    if (act_count != exp_count) begin
      fail_run($sformatf("ERROR: time %0t signal cmd_count expected %0d got %0d",
                         $time, exp_count, act_count));
    end else if (with_addr && (act_addr !== exp_addr)) begin
      fail_run($sformatf("ERROR: time %0t signal mem_cmd_addr_o expected %h got %h",
                         $time, exp_addr, act_addr));
    end
  endtask

  // Physical byte address is the tag above the untranslated page offset
  function automatic paddr_t phys_addr(input logic [31:0] va, input logic [ptag_width_gp-1:0] pt);
    return {pt, va[page_offset_width_gp-1:0]};
  endfunction

  task automatic drive_patterns();
    int idx;
    int base;
    idx = 0;
    while (idx < num_lines_lp) begin
      @(posedge clk);
      #1;
      if (hold_off) begin
        vaddr_v = 1'b0;
      end else begin
        base     = idx * fields_lp;
        vaddr    = pat_mem[base];
        ptag     = pat_mem[base+1][ptag_width_gp-1:0];
        uncached = pat_mem[base+2][0];
        vaddr_v  = 1'b1;
        @(negedge clk);
        if (vaddr_ready) begin
          idx = idx + 1;
        end else begin
          saw_full = 1'b1;
        end
      end
    end
    @(posedge clk);
    #1;
    vaddr_v = 1'b0;
  endtask

  // Instructions must come back in pattern order
  always @(negedge clk) begin
    int     base;
    int     exp_count;
    paddr_t pa;
    paddr_t exp_addr;
    if (rst_n && data_v) begin
      if (out_idx >= num_lines_lp) begin
        fail_run("An instruction came out after every pattern line had already returned");
      end else begin
        base      = out_idx * fields_lp;
        pa        = phys_addr(pat_mem[base], pat_mem[base+1][ptag_width_gp-1:0]);
        exp_addr  = pat_mem[base+2][0] ? pa : (pa & ~paddr_t'(block_bytes_lp - 1));
        exp_count = int'(pat_mem[base+4]);
        check_instr("data_o", instr_t'(pat_mem[base+3]), data);
        check_cmd_count(exp_count, cmd_count, exp_addr, last_cmd_addr,
                        exp_count != prev_count);
        if (exp_count != prev_count) begin
          check_level("mem_cmd_uncached_o", pat_mem[base+2][0], last_cmd_uncached);
        end
        prev_count = exp_count;
        out_idx    = out_idx + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_lp) begin
      fail_run("Timeout: the fetch patterns did not all return an instruction in time");
    end
  end

  initial begin
    rst_n      = 1'b0;
    vaddr      = '0;
    ptag       = '0;
    uncached   = 1'b0;
    vaddr_v    = 1'b0;
    saw_full   = 1'b0;
    out_idx    = 0;
    prev_count = 0;
    cycles     = 0;
    $readmemh("testbench/icache_fetch_patterns.txt", pat_mem);
    repeat (reset_cycles_lp - 1) @(posedge clk);
    @(negedge clk);
    check_level("data_v_o", 1'b0, data_v);
    check_level("mem_cmd_v_o", 1'b0, mem_cmd_v);
    check_level("mem_resp_yumi_o", 1'b0, mem_resp_yumi);
    check_level("miss_v_o", 1'b0, DUT.u_icache.miss_v_o);
    check_level("vaddr_ready_o", 1'b1, vaddr_ready);
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    drive_patterns();
    while (out_idx < num_lines_lp) begin
      @(posedge clk);
    end
    // Idle a while so late duplicates would still show up
    repeat (20) @(posedge clk);
    @(negedge clk);
    check_level("vaddr_ready_o", 1'b1, vaddr_ready);
    check_level("mem_cmd_v_o", 1'b0, mem_cmd_v);
    if (!saw_full) begin
      fail_run("The fetch FIFO never filled, so vaddr_ready_o back-pressure was not exercised");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* testbench/icache_fetch_patterns.txt */
// Columns: vaddr ptag uncached expected_instr cumulative_cmd_count
// All fields are hex, expected_instr is the inverse of {ptag, vaddr[11:0]}
00400100 12345 0 edcbaeff 01
00400104 12345 0 edcbaefb 01
00400108 12345 0 edcbaef7 01
0040010c 12345 0 edcbaef3 01
00400100 12345 0 edcbaeff 01
00401224 0abcd 1 f5432ddb 02
00401224 0abcd 1 f5432ddb 03
00401224 0abcd 0 f5432ddb 04
00401220 0abcd 0 f5432ddf 04
00401228 0abcd 1 f5432dd7 05
00402030 55555 0 aaaaafcf 06
00402034 66666 0 99999fcb 07
00402038 55555 0 aaaaafc7 08
0040203c 66666 0 99999fc3 09
00402030 55555 0 aaaaafcf 0a
00400104 12345 0 edcbaefb 0a
00403340 70001 0 8fffecbf 0b
00403344 70001 0 8fffecbb 0b
00403350 70001 0 8fffecaf 0c
0040335c 70001 0 8fffeca3 0c
00403348 70001 1 8fffecb7 0d
00403348 70001 0 8fffecb7 0d
0040010c 12345 0 edcbaef3 0d
004040f0 0f0f0 0 f0f0ff0f 0e
004040f4 0f0f0 0 f0f0ff0b 0e
00405100 80000 0 7ffffeff 0f
00400100 12345 0 edcbaeff 10
00402030 66666 0 99999fcf 11
00402038 66666 0 99999fc7 11
004040f8 0f0f0 1 f0f0ff07 12
004040fc 0f0f0 0 f0f0ff03 12
00403350 70001 0 8fffecaf 12
00406ee0 abcde 0 5432111f 13
00406eec abcde 0 54321113 13

/* src.f */
verilog/icache_pkg.sv
verilog/fetch_replay_fifo.sv
verilog/icache.sv
verilog/icache_fill_engine.sv
verilog/mem_resp_buffer.sv
verilog/icache_subsystem.sv
testbench/tb_mem_model.sv
testbench/tb_icache_subsystem.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_icache_subsystem -f src.f -o tb_sim

out=$(./obj_dir/tb_sim) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^TESTS PASSED$"; then
  exit 0
else
  exit 1
fi
